// File: Bender.yml
package:
  name: via6522_lite

sources:
  - design/viaBusPkg.sv
  - design/viaTimerPkg.sv
  - design/viaHostIf.sv
  - design/viaPortRegs.sv
  - design/viaIrqCtrl.sv
  - design/viaTimerFsm.sv
  - design/viaTimerCounter.sv
  - design/via6522Lite.sv
  - target: test
    files:
      - dv/viaClockGen.sv
      - dv/via6522Lite_props.sv
      - dv/via6522LiteTb.sv

// File: design/via6522Lite.sv
/*
 * Reduced 6522 VIA.
 * Two 8-bit ports, CA1/CA2 edge interrupts and timer 1, on a host bus
 * qualified by clkEn, with an active-low interrupt request.
 */
`timescale 1ns/1ps
`default_nettype none

module via6522Lite #(
	parameter int SyncStages = 2
) (
	input  wire                  clk,
	input  wire                  IFR,
	input  wire                  clkEn,
	input  wire                  cs1,
	input  wire                  cs2N,
	input  wire                  rnw,
	input  viaBusPkg::viaRegSel  sel,
	input  viaBusPkg::viaByte    wdata,
	input  wire                  ca1,
	input  wire                  ca2,
	input  viaBusPkg::viaByte    portAIn,
	input  viaBusPkg::viaByte    portBIn,
	output viaBusPkg::viaByte    rdata,
	output viaBusPkg::viaByte    portAOut,
	output viaBusPkg::viaByte    portAOe,
	output viaBusPkg::viaByte    portBOut,
	output viaBusPkg::viaByte    portBOe,
	output wire                  nIrq
);

	import viaBusPkg::*;

	viaAccess acc;
	viaByte   portRegsRd;
	viaByte   irqRd;
	viaByte   acrRd;
	viaByte   timerRd;
	logic     expired;
	logic     t1Event;

	viaHostIf viaHostIf_i (.clkEn(clkEn), .cs1(cs1), .cs2N(cs2N), .rnw(rnw), .sel(sel),
		.wdata(wdata), .portRegsRd(portRegsRd), .irqRd(irqRd), .acrRd(acrRd),
		.timerRd(timerRd), .acc(acc), .rdata(rdata));

	viaPortRegs viaPortRegs_i (.clk(clk), .IFR(IFR), .acc(acc), .portAIn(portAIn),
		.portBIn(portBIn), .portAOut(portAOut), .portAOe(portAOe), .portBOut(portBOut),
		.portBOe(portBOe), .portRegsRd(portRegsRd));

	viaIrqCtrl #(.SyncStages(SyncStages)) viaIrqCtrl_i (.clk(clk), .IFR(IFR), .acc(acc),
		.ca1(ca1), .ca2(ca2), .t1Event(t1Event), .irqRd(irqRd), .nIrq(nIrq));

	viaTimerFsm viaTimerFsm_i (.clk(clk), .IFR(IFR), .acc(acc), .expired(expired),
		.t1Event(t1Event), .acrRd(acrRd));

	viaTimerCounter viaTimerCounter_i (.clk(clk), .IFR(IFR), .clkEn(clkEn), .acc(acc),
		.expired(expired), .timerRd(timerRd));

endmodule

`default_nettype wire

// File: design/viaBusPkg.sv
/*
 * VIA host-bus definitions.
 * Data byte, register select codes, the qualified host access
 * and the bit positions inside the interrupt flag and enable registers.
 */
`default_nettype none

package viaBusPkg;

	typedef logic [7:0] viaByte;

	typedef logic [6:0] viaIntVec; // one bit per interrupt source, bit 7 is never stored

	typedef enum logic [3:0] {
		regOrb     = 4'h0,
		regOra     = 4'h1,
		regDdrb    = 4'h2,
		regDdra    = 4'h3,
		regT1Lo    = 4'h4,
		regT1Hi    = 4'h5,
		regT1LatLo = 4'h6,
		regT1LatHi = 4'h7,
		regAcr     = 4'hB,
		regPcr     = 4'hC,
		regIfr     = 4'hD,
		regIer     = 4'hE,
		regOraNh   = 4'hF
	} viaRegSel;

	// wr and rd are already qualified by chip select and clkEn
	typedef struct packed {
		logic     wr;
		logic     rd;
		viaRegSel sel;
		viaByte   wdata;
	} viaAccess;

	typedef enum int {
		intCa2 = 0,
		intCa1 = 1,
		intT1  = 6
	} intFlagBits;

endpackage

`default_nettype wire

// File: design/viaHostIf.sv
/*
 * VIA host interface.
 * Combines the chip selects and clkEn into one qualified access and
 * routes the read-back byte of the owning block onto rdata.
 */
`timescale 1ns/1ps
`default_nettype none

module viaHostIf (
	input  wire                  clkEn,
	input  wire                  cs1,
	input  wire                  cs2N,
	input  wire                  rnw,
	input  viaBusPkg::viaRegSel  sel,
	input  viaBusPkg::viaByte    wdata,
	input  viaBusPkg::viaByte    portRegsRd,
	input  viaBusPkg::viaByte    irqRd,
	input  viaBusPkg::viaByte    acrRd,
	input  viaBusPkg::viaByte    timerRd,
	output viaBusPkg::viaAccess  acc,
	output viaBusPkg::viaByte    rdata
);

	import viaBusPkg::*;

	logic chipSel;
	logic readSel;

	assign chipSel = cs1 & ~cs2N;
	assign readSel = chipSel & rnw; // read data does not wait for clkEn

	always_comb begin
		acc.wr    = chipSel & clkEn & ~rnw;
		acc.rd    = chipSel & clkEn & rnw; // strobe for read side effects
		acc.sel   = sel;
		acc.wdata = wdata;
	end

	always_comb begin
		rdata = '0;
		if (readSel) begin
			case (sel)
				regOrb, regOra, regDdrb, regDdra, regOraNh: begin
					rdata = portRegsRd;
				end
				regT1Lo, regT1Hi, regT1LatLo, regT1LatHi: begin
					rdata = timerRd;
				end
				regAcr: begin
					rdata = acrRd;
				end
				regPcr, regIfr, regIer: begin
					rdata = irqRd;
				end
				default: begin
					rdata = '0; // unmapped selects read as zero
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/viaIrqCtrl.sv
/*
 * VIA interrupt control.
 * Synchronizes CA1/CA2, detects the edge chosen in PCR, and keeps the
 * interrupt flag and enable registers that drive the active-low nIrq.
 */
`timescale 1ns/1ps
`default_nettype none

module viaIrqCtrl #(
	parameter int SyncStages = 2
) (
	input  wire                  clk,
	input  wire                  IFR,
	input  viaBusPkg::viaAccess  acc,
	input  wire                  ca1,
	input  wire                  ca2,
	input  wire                  t1Event,
	output viaBusPkg::viaByte    irqRd,
	output logic                 nIrq
);

	import viaBusPkg::*;

	logic [SyncStages-1:0][1:0] caSync; // bit 1 is CA1, bit 0 is CA2, as in the flags
	logic [1:0] caPrev;
	logic [1:0] caRise;
	logic [1:0] caEdge;
	viaByte     pcr;
	viaIntVec   intFlags;
	viaIntVec   intEnables;
	viaIntVec   setVec;
	viaIntVec   clrVec;
	logic       anyIrq;
	logic       oraAccess;

	always_ff @(posedge clk or posedge IFR) begin
		if (IFR) begin
			caSync <= '0;
			caPrev <= '0;
		end else begin
			caSync[0] <= {ca1, ca2};
			for (int i = 1; i < SyncStages; i++) begin
				caSync[i] <= caSync[i-1];
			end
			caPrev <= caSync[SyncStages-1];
		end
	end

	assign caRise = {pcr[0], pcr[2]}; // 1 selects the rising edge
	assign caEdge = (caSync[SyncStages-1] & ~caPrev & caRise)
		| (~caSync[SyncStages-1] & caPrev & ~caRise);

	assign oraAccess = (acc.rd | acc.wr) & ((acc.sel == regOra) | (acc.sel == regOraNh));

	always_comb begin
		setVec         = '0;
		setVec[intCa1] = caEdge[1];
		setVec[intCa2] = caEdge[0];
		setVec[intT1]  = t1Event;

		clrVec = '0;
		if (acc.wr && acc.sel == regIfr) begin
			clrVec = acc.wdata[6:0]; // each 1 clears its flag
		end
		if (oraAccess) begin
			clrVec[intCa1] = 1'b1;
			clrVec[intCa2] = 1'b1;
		end
		if ((acc.rd && acc.sel == regT1Lo) || (acc.wr && acc.sel == regT1Hi)) begin
			clrVec[intT1] = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge IFR) begin
		if (IFR) begin
			pcr        <= '0;
			intFlags   <= '0;
			intEnables <= '0;
			nIrq       <= 1'b1;
		end else begin
			intFlags <= (intFlags & ~clrVec) | setVec; // a new event wins over a clear
			nIrq     <= ~anyIrq;
			if (acc.wr && acc.sel == regPcr) begin
				pcr <= acc.wdata;
			end
			if (acc.wr && acc.sel == regIer) begin
				intEnables <= acc.wdata[7] ? (intEnables | acc.wdata[6:0])
					: (intEnables & ~acc.wdata[6:0]);
			end
		end
	end

	assign anyIrq = |(intFlags & intEnables);

	always_comb begin
		case (acc.sel)
			regPcr:  irqRd = pcr;
			regIfr:  irqRd = {anyIrq, intFlags};
			regIer:  irqRd = {1'b1, intEnables};
			default: irqRd = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/viaPortRegs.sv
/*
 * VIA parallel ports A and B.
 * Output and data direction registers, with pin read-back that mixes
 * driven bits and input pins according to the direction bits.
 */
`timescale 1ns/1ps
`default_nettype none

module viaPortRegs (
	input  wire                  clk,
	input  wire                  IFR,
	input  viaBusPkg::viaAccess  acc,
	input  viaBusPkg::viaByte    portAIn,
	input  viaBusPkg::viaByte    portBIn,
	output viaBusPkg::viaByte    portAOut,
	output viaBusPkg::viaByte    portAOe,
	output viaBusPkg::viaByte    portBOut,
	output viaBusPkg::viaByte    portBOe,
	output viaBusPkg::viaByte    portRegsRd
);

	import viaBusPkg::*;

	viaByte ora;
	viaByte orb;
	viaByte ddra;
	viaByte ddrb;

	always_ff @(posedge clk or posedge IFR) begin
		if (IFR) begin
			ora  <= '0;
			orb  <= '0;
			ddra <= '0;
			ddrb <= '0;
		end else if (acc.wr) begin
			case (acc.sel)
				regOrb:           orb  <= acc.wdata;
				regOra, regOraNh: ora  <= acc.wdata; // both addresses reach ORA
				regDdrb:          ddrb <= acc.wdata;
				regDdra:          ddra <= acc.wdata;
				default:          ;
			endcase
		end
	end

	assign portAOut = ora;
	assign portAOe  = ddra; // a direction bit of 1 enables the pin driver
	assign portBOut = orb;
	assign portBOe  = ddrb;

	always_comb begin
		case (acc.sel)
			regOrb:           portRegsRd = (orb & ddrb) | (portBIn & ~ddrb);
			regOra, regOraNh: portRegsRd = (ora & ddra) | (portAIn & ~ddra);
			regDdrb:          portRegsRd = ddrb;
			regDdra:          portRegsRd = ddra;
			default:          portRegsRd = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/viaTimerCounter.sv
/*
 * VIA timer 1 datapath.
 * 16-bit latch and down-counter: loaded by a high-byte write, counts on
 * clkEn, and reloads from the latch when it reaches zero.
 */
`timescale 1ns/1ps
`default_nettype none

module viaTimerCounter (
	input  wire                  clk,
	input  wire                  IFR,
	input  wire                  clkEn,
	input  viaBusPkg::viaAccess  acc,
	output logic                 expired,
	output viaBusPkg::viaByte    timerRd
);

	import viaBusPkg::*;
	import viaTimerPkg::*;

	viaCount t1Latch;
	viaCount t1Count;
	logic    t1HiWrite;

	assign t1HiWrite = acc.wr & (acc.sel == regT1Hi);
	assign expired   = clkEn & ~t1HiWrite & (t1Count == '0);

	always_ff @(posedge clk or posedge IFR) begin
		if (IFR) begin
			t1Latch <= '0;
			t1Count <= '0;
		end else begin
			if (acc.wr && (acc.sel == regT1Lo || acc.sel == regT1LatLo)) t1Latch[7:0] <= acc.wdata;
			if (acc.wr && acc.sel == regT1LatHi) t1Latch[15:8] <= acc.wdata;
			if (t1HiWrite) begin
				t1Count <= {acc.wdata, t1Latch[7:0]};
			end else if (expired) begin
				t1Count <= t1Latch; // zero reached, so the period is latch+1
			end else if (clkEn) begin
				t1Count <= t1Count - 1'b1;
			end
		end
	end

	always_comb begin
		case (acc.sel)
			regT1Lo:    timerRd = t1Count[7:0];
			regT1Hi:    timerRd = t1Count[15:8];
			regT1LatLo: timerRd = t1Latch[7:0];
			regT1LatHi: timerRd = t1Latch[15:8];
			default:    timerRd = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/viaTimerFsm.sv
/*
 * VIA timer 1 control.
 * Holds ACR and the arm/disarm machine that turns counter expiries into
 * single-cycle T1 interrupt events, once or repeatedly.
 */
`timescale 1ns/1ps
`default_nettype none

module viaTimerFsm (
	input  wire                  clk,
	input  wire                  IFR,
	input  viaBusPkg::viaAccess  acc,
	input  wire                  expired,
	output logic                 t1Event,
	output viaBusPkg::viaByte    acrRd
);

	import viaBusPkg::*;
	import viaTimerPkg::*;

	viaByte    acr;
	timerState state;
	timerState stateNext;
	logic      fire;
	logic      t1HiWrite;

	assign t1HiWrite = acc.wr & (acc.sel == regT1Hi);
	assign fire      = expired & (state == timArmed);

	always_comb begin
		stateNext = state;
		case (state)
			timIdle: begin
				if (t1HiWrite) stateNext = timArmed;
			end
			timArmed: begin
				if (t1HiWrite) begin
					stateNext = timArmed; // reloading restarts the shot
				end else if (expired && !acr[6]) begin
					stateNext = timIdle; // one-shot mode disarms after its event
				end
			end
			default: stateNext = timIdle;
		endcase
	end

	always_ff @(posedge clk or posedge IFR) begin
		if (IFR) begin
			acr     <= '0;
			state   <= timIdle;
			t1Event <= 1'b0;
		end else begin
			state   <= stateNext;
			t1Event <= fire & ~t1HiWrite;
			if (acc.wr && acc.sel == regAcr) begin
				acr <= acc.wdata;
			end
		end
	end

	assign acrRd = (acc.sel == regAcr) ? acr : '0;

endmodule

`default_nettype wire

// File: design/viaTimerPkg.sv
/*
 * Timer 1 definitions.
 * Count and latch width, and the states of the arm/disarm machine.
 */
`default_nettype none

package viaTimerPkg;

	typedef logic [15:0] viaCount;

	// armed means the next expiry raises the T1 interrupt
	typedef enum logic {
		timIdle  = 1'b0,
		timArmed = 1'b1
	} timerState;

endpackage

`default_nettype wire

// File: dv/via6522LiteTb.sv
/*
 * Testbench for the reduced 6522 VIA.
 * Applies a table of bus accesses, CA pin changes and interrupt waits,
 * then checks the port pins against random input patterns.
 */
`timescale 1ns/1ps
`default_nettype none

module via6522LiteTb;

	import viaBusPkg::*;

	typedef enum logic [2:0] {
		opWr, opRd, opStrobe, opCa, opIdle, opWaitLow, opWaitHigh, opEn
	} stepOp;

	// data is a write value, the pins {ca1, ca2}, a cycle count or the clkEn level
	typedef struct packed {
		stepOp    op;
		viaRegSel sel;
		viaByte   data;
		viaByte   expected;
	} stepEntry;

	localparam int NumSteps  = 71;
	localparam int WaitLimit = 200;

	localparam stepEntry Steps [NumSteps] = '{
		'{opRd, regOrb, 8'h00, 8'h00}, '{opRd, regOra, 8'h00, 8'h00},
		'{opRd, regDdrb, 8'h00, 8'h00}, '{opRd, regDdra, 8'h00, 8'h00},
		'{opRd, regT1Lo, 8'h00, 8'h00}, '{opRd, regT1Hi, 8'h00, 8'h00},
		'{opRd, regT1LatLo, 8'h00, 8'h00}, '{opRd, regT1LatHi, 8'h00, 8'h00},
		'{opRd, regAcr, 8'h00, 8'h00}, '{opRd, regPcr, 8'h00, 8'h00},
		'{opRd, regIfr, 8'h00, 8'h00}, '{opRd, regIer, 8'h00, 8'h80},
		'{opRd, regOraNh, 8'h00, 8'h00},
		'{opWr, regIer, 8'h83, 8'h00}, '{opRd, regIer, 8'h00, 8'h83},
		'{opWr, regIer, 8'h01, 8'h00}, '{opRd, regIer, 8'h00, 8'h82},
		'{opWr, regIer, 8'h7F, 8'h00}, '{opRd, regIer, 8'h00, 8'h80},
		// CA1 and CA2 rising set flags that are pending before they are enabled
		'{opWr, regPcr, 8'h05, 8'h00}, '{opCa, regOrb, 8'h03, 8'h00},
		'{opIdle, regOrb, 8'h06, 8'h00}, '{opRd, regIfr, 8'h00, 8'h03},
		'{opWr, regIer, 8'h82, 8'h00}, '{opWaitLow, regOrb, 8'h00, 8'h00},
		'{opRd, regIfr, 8'h00, 8'h83}, '{opRd, regOra, 8'h00, 8'h00},
		'{opWaitHigh, regOrb, 8'h00, 8'h00}, '{opRd, regIfr, 8'h00, 8'h00},
		'{opCa, regOrb, 8'h00, 8'h00}, '{opIdle, regOrb, 8'h06, 8'h00},
		'{opRd, regIfr, 8'h00, 8'h00}, '{opCa, regOrb, 8'h01, 8'h00},
		'{opIdle, regOrb, 8'h06, 8'h00}, '{opRd, regIfr, 8'h00, 8'h01},
		'{opWr, regIfr, 8'h01, 8'h00}, '{opRd, regIfr, 8'h00, 8'h00},
		'{opWr, regPcr, 8'h01, 8'h00}, '{opCa, regOrb, 8'h03, 8'h00},
		'{opIdle, regOrb, 8'h06, 8'h00}, '{opCa, regOrb, 8'h02, 8'h00},
		'{opIdle, regOrb, 8'h06, 8'h00}, '{opRd, regIfr, 8'h00, 8'h83},
		'{opWr, regIfr, 8'h01, 8'h00}, '{opRd, regIfr, 8'h00, 8'h82},
		'{opWr, regIfr, 8'h02, 8'h00}, '{opWaitHigh, regOrb, 8'h00, 8'h00},
		'{opRd, regIfr, 8'h00, 8'h00},
		// timer 1 one-shot, then free-run, with a period of 17 cycles
		'{opWr, regIer, 8'hC0, 8'h00}, '{opWr, regT1Lo, 8'h10, 8'h00},
		'{opWr, regT1Hi, 8'h00, 8'h00}, '{opWaitLow, regOrb, 8'h00, 8'h00},
		'{opStrobe, regT1Lo, 8'h00, 8'h00}, '{opWaitHigh, regOrb, 8'h00, 8'h00},
		'{opIdle, regOrb, 8'd40, 8'h00}, '{opRd, regIfr, 8'h00, 8'h00},
		'{opWr, regAcr, 8'h40, 8'h00}, '{opWr, regT1Hi, 8'h00, 8'h00},
		'{opWaitLow, regOrb, 8'h00, 8'h00}, '{opStrobe, regT1Lo, 8'h00, 8'h00},
		'{opWaitHigh, regOrb, 8'h00, 8'h00}, '{opWaitLow, regOrb, 8'h00, 8'h00},
		// counter is 16'h1210 when clkEn drops
		'{opWr, regT1Hi, 8'h12, 8'h00}, '{opEn, regOrb, 8'h00, 8'h00},
		'{opRd, regT1Lo, 8'h00, 8'h10}, '{opRd, regT1Hi, 8'h00, 8'h12},
		'{opWr, regDdra, 8'h55, 8'h00}, '{opIdle, regOrb, 8'h05, 8'h00},
		'{opRd, regT1Lo, 8'h00, 8'h10}, '{opRd, regDdra, 8'h00, 8'h00},
		'{opEn, regOrb, 8'h01, 8'h00}
	};

	logic     clk;
	logic     IFR;
	logic     clkEn, cs1, cs2N, rnw, ca1, ca2;
	logic     nIrq;
	viaRegSel sel;
	viaByte   wdata, portAIn, portBIn;
	viaByte   rdata, portAOut, portAOe, portBOut, portBOe;
	int       seed = 32'h08e87f09;

	viaClockGen viaClockGen_i (.clk(clk), .IFR(IFR));

	via6522Lite #(.SyncStages(2)) via6522Lite_i (.*);

	task automatic abortRun();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic checkByte(string name, viaByte got, viaByte want);
		if (got !== want) begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, want);
			abortRun();
		end
	endtask

	task automatic checkLevel(string name, logic got, logic want);
		if (got !== want) begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, want);
			abortRun();
		end
	endtask

	task automatic releaseBus();
		@(negedge clk);
		cs1 = 1'b0;
		rnw = 1'b1;
	endtask

	// one access, driven on the falling edge and taking effect at the next rising edge
	task automatic busAccess(logic isRead, logic check, viaRegSel s, viaByte d, viaByte want);
		@(negedge clk);
		cs1   = 1'b1;
		rnw   = isRead;
		sel   = s;
		wdata = d;
		#20;
		if (check) checkByte($sformatf("rdata(%s)", s.name()), rdata, want);
		@(posedge clk);
	endtask

	task automatic waitIrq(logic level, int index);
		int count;
		count = 0;
		releaseBus();
		while (nIrq !== level && count < WaitLimit) begin
			@(negedge clk);
			count++;
		end
		if (nIrq !== level) begin
			$display("timeout at step %0d: nIrq did not go %s", index,
				level ? "high" : "low");
			abortRun();
		end
	endtask

	task automatic waitResetRelease();
		int count;
		count = 0;
		@(posedge clk);
		while (IFR !== 1'b0 && count < 40) begin
			@(posedge clk);
			count++;
		end
		@(negedge clk);
		if (IFR !== 1'b0) begin
			$display("timeout: reset was never released");
			abortRun();
		end
	endtask

	task automatic runStep(stepEntry s, int index);
		case (s.op)
			opWr:       busAccess(1'b0, 1'b0, s.sel, s.data, 8'h00);
			opRd:       busAccess(1'b1, 1'b1, s.sel, 8'h00, s.expected);
			opStrobe:   busAccess(1'b1, 1'b0, s.sel, 8'h00, 8'h00); // side effect only
			opCa: begin
				releaseBus();
				{ca1, ca2} = s.data[1:0];
			end
			opEn: begin
				releaseBus();
				clkEn = s.data[0];
			end
			opIdle: begin
				releaseBus();
				repeat (s.data) @(negedge clk);
			end
			opWaitLow:  waitIrq(1'b0, index);
			opWaitHigh: waitIrq(1'b1, index);
			default:    ;
		endcase
	endtask

	initial begin
		clkEn   = 1'b1;
		cs1     = 1'b0;
		cs2N    = 1'b0;
		rnw     = 1'b1;
		sel     = regOrb;
		wdata   = '0;
		ca1     = 1'b0;
		ca2     = 1'b0;
		portAIn = '0;
		portBIn = '0;
		waitResetRelease();
		checkLevel("nIrq", nIrq, 1'b1);
		checkByte("portAOe", portAOe, 8'h00);
		checkByte("portBOe", portBOe, 8'h00);
		for (int i = 0; i < NumSteps; i++) begin
			runStep(Steps[i], i);
		end
		busAccess(1'b0, 1'b0, regDdra, 8'hF0, 8'h00);
		busAccess(1'b0, 1'b0, regOra, 8'hA5, 8'h00);
		busAccess(1'b0, 1'b0, regDdrb, 8'h0F, 8'h00);
		busAccess(1'b0, 1'b0, regOrb, 8'h3C, 8'h00);
		releaseBus();
		checkByte("portAOut", portAOut, 8'hA5);
		checkByte("portAOe", portAOe, 8'hF0);
		checkByte("portBOut", portBOut, 8'h3C);
		checkByte("portBOe", portBOe, 8'h0F);
		repeat (4) begin
			releaseBus();
			portAIn = viaByte'($random(seed));
			portBIn = viaByte'($random(seed));
			// driven bits read back from the output register, the rest from the pins
			busAccess(1'b1, 1'b1, regOra, 8'h00, (8'hA5 & 8'hF0) | (portAIn & 8'h0F));
			busAccess(1'b1, 1'b1, regOrb, 8'h00, (8'h3C & 8'h0F) | (portBIn & 8'hF0));
		end
		releaseBus();
		if (via6522Lite_i.props_i.failCount == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("%0d assertion failures", via6522Lite_i.props_i.failCount);
			abortRun();
		end
	end

endmodule

`default_nettype wire

// File: dv/via6522Lite_props.sv
/*
 * Interrupt and timer 1 properties of the VIA, bound into the top level.
 */
`timescale 1ns/1ps
`default_nettype none

module via6522Lite_props (
	input wire                 clk,
	input wire                 IFR,
	input wire                 nIrq,
	input wire                 t1Event,
	input viaBusPkg::viaIntVec intFlags,
	input viaBusPkg::viaIntVec intEnables
);

	int failCount = 0;

	assert property (@(posedge clk) IFR |-> nIrq) else begin
		failCount++;
		$error("nIrq is active while the VIA is in reset");
	end

	assert property (@(posedge clk) disable iff (IFR) t1Event |=> !t1Event) else begin
		failCount++;
		$error("t1Event lasted longer than one cycle");
	end

	// nIrq is the registered inverse of any enabled flag
	assert property (@(posedge clk) disable iff (IFR)
		nIrq == !$past(|(intFlags & intEnables))) else begin
		failCount++;
		$error("nIrq does not follow the flag and enable registers");
	end

endmodule

bind via6522Lite via6522Lite_props props_i (.clk(clk), .IFR(IFR), .nIrq(nIrq),
	.t1Event(t1Event), .intFlags(viaIrqCtrl_i.intFlags),
	.intEnables(viaIrqCtrl_i.intEnables));

`default_nettype wire

// File: dv/viaClockGen.sv
/*
 * Testbench clock and reset for the VIA.
 * 100 ns clock, with IFR held high for the first 16 cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module viaClockGen (
	output logic clk,
	output logic IFR
);

	initial begin
		clk = 1'b0;
		IFR = 1'b0;
		#1;
		IFR = 1'b1; // a real rising edge, so the asynchronous reset fires
		repeat (16) @(posedge clk);
		@(negedge clk);
		IFR = 1'b0;
	end

	always #50 clk = ~clk;

endmodule

`default_nettype wire

// File: sources.f
design/viaBusPkg.sv
design/viaTimerPkg.sv
design/viaHostIf.sv
design/viaPortRegs.sv
design/viaIrqCtrl.sv
design/viaTimerFsm.sv
design/viaTimerCounter.sv
design/via6522Lite.sv
dv/viaClockGen.sv
dv/via6522Lite_props.sv
dv/via6522LiteTb.sv
